/* Bender.yml */
package:
  name: lsu

sources:
  - logic/lsu_pkg.sv
  - logic/obi_bus_if.sv
  - logic/lsu_decode.sv
  - logic/obi_master.sv
  - logic/lsu_result.sv
  - logic/obi_sram.sv
  - logic/lsu_top.sv
  - target: simulation
    files:
      - tb/tb_lsu_top.sv

/* logic/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF
) (
    input  logic [ADDR_WIDTH-1:0] core_addr_i,
    input  logic                  core_we_i,
    input  lsu_size_e             core_size_i,
    input  logic                  core_unsigned_i,
    input  logic [31:0]           core_wdata_i,
    output lsu_req_t              dec_req_o
);

    // byte offset inside the addressed word
    logic [1:0]          offset;
    logic [BE_WIDTH-1:0] be;
    logic                misaligned;

    assign offset = core_addr_i[1:0];

    // lane selection and alignment check
    always_comb begin
        be         = '0;
        misaligned = 1'b0;
        unique case (core_size_i)
            BYTE: begin
                // any offset is fine for a single byte
                be = 4'b0001 << offset;
            end
            HALF: begin
                // lower or upper half of the word
                be = 4'b0011 << {offset[1], 1'b0};
                // odd offset would split the halfword
                misaligned = offset[0];
            end
            WORD: begin
                be = 4'b1111;
                misaligned = (offset != 2'b00);
            end
            default: begin
                // unused size code, reject it like a misaligned access
                be = '0;
                misaligned = 1'b1;
            end
        endcase
    end

    // pack the decoded request
    always_comb begin
        // bus always sees a word address
        dec_req_o.addr        = ADDR_WIDTH_DEF'({core_addr_i[ADDR_WIDTH-1:2], 2'b00});
        dec_req_o.we          = core_we_i;
        dec_req_o.be          = be;
        // store data moves up by the offset so the low bytes land in the selected lanes
        dec_req_o.wdata       = core_wdata_i << {offset, 3'b000};
        dec_req_o.size        = core_size_i;
        dec_req_o.is_unsigned = core_unsigned_i;
        dec_req_o.offset      = offset;
        dec_req_o.misaligned  = misaligned;
    end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

    // default bus widths, data stays at 32 bits (four byte lanes)
    localparam int ADDR_WIDTH_DEF = 32;
    localparam int DATA_WIDTH_DEF = 32;
    // one enable bit per byte lane
    localparam int BE_WIDTH       = DATA_WIDTH_DEF / 8;

    // access size as seen on the core side
    // 2'b11 is not a legal size and is treated as misaligned
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } lsu_size_e;

    // decoded request, built by lsu_decode and latched by obi_master
    typedef struct packed {
        // word aligned address, low two bits always zero
        logic [ADDR_WIDTH_DEF-1:0] addr;
        // store when set, load otherwise
        logic                      we;
        // lanes touched by the access
        logic [BE_WIDTH-1:0]       be;
        // store data already moved into its lanes
        logic [DATA_WIDTH_DEF-1:0] wdata;
        // size and extension kind, needed again for load formatting
        lsu_size_e                 size;
        logic                      is_unsigned;
        // byte offset inside the word
        logic [1:0]                offset;
        // access crosses its natural boundary, never reaches the bus
        logic                      misaligned;
    } lsu_req_t;

endpackage

/* logic/lsu_result.sv */
`timescale 1ns/1ps

module lsu_result import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rsp_strobe_i,
    input  logic [31:0] rsp_rdata_i,
    input  logic        rsp_err_i,
    input  lsu_req_t    rsp_req_i,
    output logic        resp_valid_o,
    output logic [31:0] resp_rdata_o,
    output logic        resp_err_o
);

    logic [31:0] shifted;
    logic [31:0] load_data;

    // bring the addressed byte or halfword down to bit 0
    assign shifted = rsp_rdata_i >> {rsp_req_i.offset, 3'b000};

    // extension by size
    always_comb begin
        unique case (rsp_req_i.size)
            BYTE: begin
                if (rsp_req_i.is_unsigned) begin
                    load_data = {24'b0, shifted[7:0]};
                end else begin
                    load_data = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            HALF: begin
                if (rsp_req_i.is_unsigned) begin
                    load_data = {16'b0, shifted[15:0]};
                end else begin
                    load_data = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            WORD: begin
                load_data = shifted;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    // control, the pulse follows the strobe by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
            resp_err_o   <= 1'b0;
        end else begin
            resp_valid_o <= rsp_strobe_i;
            resp_err_o   <= rsp_strobe_i && rsp_err_i;
        end
    end

    // data, stores and errors give zero
    always_ff @(posedge clk) begin
        if (rsp_strobe_i) begin
            resp_rdata_o <= (rsp_req_i.we || rsp_err_i) ? '0 : load_data;
        end
    end

    // master spends one cycle in dumping, so the pulse never stretches
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o |=> !resp_valid_o);

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF,
    parameter int MEM_WORDS  = 256,
    parameter int GNT_WAIT   = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // core request
    input  logic                  core_valid_i,
    output logic                  core_ready_o,
    input  logic [ADDR_WIDTH-1:0] core_addr_i,
    input  logic                  core_we_i,
    input  lsu_size_e             core_size_i,
    input  logic                  core_unsigned_i,
    input  logic [31:0]           core_wdata_i,
    // core response, consumer always ready
    output logic                  resp_valid_o,
    output logic [31:0]           resp_rdata_o,
    output logic                  resp_err_o
);

    lsu_req_t    dec_req;
    lsu_req_t    rsp_req;
    logic        rsp_strobe;
    logic [31:0] rsp_rdata;
    logic        rsp_err;

    obi_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) bus ();

    // size and address to lanes
    lsu_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_decode (
        .core_addr_i     (core_addr_i),
        .core_we_i       (core_we_i),
        .core_size_i     (core_size_i),
        .core_unsigned_i (core_unsigned_i),
        .core_wdata_i    (core_wdata_i),
        .dec_req_o       (dec_req)
    );

    // bus handshake
    obi_master #(.ADDR_WIDTH(ADDR_WIDTH)) u_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_valid_i (core_valid_i),
        .core_ready_o (core_ready_o),
        .dec_req_i    (dec_req),
        .bus          (bus.master),
        .rsp_strobe_o (rsp_strobe),
        .rsp_rdata_o  (rsp_rdata),
        .rsp_err_o    (rsp_err),
        .rsp_req_o    (rsp_req)
    );

    // load extraction and response pulse
    lsu_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .rsp_strobe_i (rsp_strobe),
        .rsp_rdata_i  (rsp_rdata),
        .rsp_err_i    (rsp_err),
        .rsp_req_i    (rsp_req),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o)
    );

    obi_sram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS),
        .GNT_WAIT   (GNT_WAIT)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.slave)
    );

endmodule

/* logic/obi_bus_if.sv */
`timescale 1ns/1ps

interface obi_bus_if import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF
);

    // address phase, held by the master until req and gnt meet on an edge
    logic                      req;
    logic                      gnt;
    logic [ADDR_WIDTH-1:0]     addr;
    logic                      we;
    logic [BE_WIDTH-1:0]       be;
    logic [DATA_WIDTH_DEF-1:0] wdata;

    // response phase, rvalid is a single cycle pulse
    // rdata and err only mean something while rvalid is high
    logic [DATA_WIDTH_DEF-1:0] rdata;
    logic                      rvalid;
    logic                      err;

    // lsu side of the bus
    modport master (
        output req, addr, we, be, wdata,
        input  gnt, rdata, rvalid, err
    );

    // memory side of the bus
    modport slave (
        input  req, addr, we, be, wdata,
        output gnt, rdata, rvalid, err
    );

endinterface

/* logic/obi_master.sv */
`timescale 1ns/1ps

module obi_master import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_valid_i,
    output logic        core_ready_o,
    input  lsu_req_t    dec_req_i,
    obi_bus_if.master   bus,
    output logic        rsp_strobe_o,
    output logic [31:0] rsp_rdata_o,
    output logic        rsp_err_o,
    output lsu_req_t    rsp_req_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQUESTING,
        WAITING,
        DUMPING
    } obi_state_e;

    obi_state_e  state;
    lsu_req_t    req_q;
    logic [31:0] rdata_q;
    logic        err_q;
    logic        accept;

    // one transaction at a time, so only idle takes a new request
    assign core_ready_o = (state == IDLE);
    assign accept       = core_valid_i && core_ready_o;

    // state and bus request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            bus.req <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (accept) begin
                        // misaligned access answers locally, no bus cycle
                        if (dec_req_i.misaligned) begin
                            state <= DUMPING;
                        end else begin
                            state   <= REQUESTING;
                            bus.req <= 1'b1;
                        end
                    end
                end
                REQUESTING: begin
                    // address phase ends on the grant edge
                    if (bus.gnt) begin
                        state   <= WAITING;
                        bus.req <= 1'b0;
                    end
                end
                WAITING: begin
                    if (bus.rvalid) begin
                        state <= DUMPING;
                    end
                end
                DUMPING: begin
                    // strobe is up for this single cycle
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request fields and response capture
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q     <= dec_req_i;
            bus.addr  <= ADDR_WIDTH'(dec_req_i.addr);
            bus.we    <= dec_req_i.we;
            bus.be    <= dec_req_i.be;
            bus.wdata <= dec_req_i.wdata;
            // preset for the local error path
            rdata_q   <= '0;
            err_q     <= dec_req_i.misaligned;
        end else if ((state == WAITING) && bus.rvalid) begin
            rdata_q <= bus.rdata;
            err_q   <= bus.err;
        end
    end

    assign rsp_strobe_o = (state == DUMPING);
    assign rsp_rdata_o  = rdata_q;
    assign rsp_err_o    = err_q;
    assign rsp_req_o    = req_q;

    // slave may stall, the address phase must not change meanwhile
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.we)
            && $stable(bus.be) && $stable(bus.wdata));

    // a response with nothing outstanding means the slave lost track
    a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> !bus.rvalid);

endmodule

/* logic/obi_sram.sv */
`timescale 1ns/1ps

module obi_sram import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF,
    parameter int MEM_WORDS  = 256,
    parameter int GNT_WAIT   = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    obi_bus_if.slave bus
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (GNT_WAIT > 0) ? $clog2(GNT_WAIT + 1) : 1;

    logic [DATA_WIDTH_DEF-1:0] mem [MEM_WORDS];
    logic [CNT_W-1:0]          wait_cnt;
    logic [ADDR_WIDTH-3:0]     word_idx;
    logic                      in_range;
    logic                      grant;

    assign word_idx = bus.addr[ADDR_WIDTH-1:2];
    assign in_range = (word_idx < (ADDR_WIDTH-2)'(MEM_WORDS));

    // grant once the request has waited GNT_WAIT cycles
    // zero wait grants in the same cycle as req
    assign bus.gnt = bus.req && (wait_cnt == CNT_W'(GNT_WAIT));
    assign grant   = bus.req && bus.gnt;

    // cycles spent with req pending
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (bus.req && !bus.gnt) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // storage and response pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= grant;
            // out of range store is dropped
            if (grant && bus.we && in_range) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (bus.be[b]) begin
                        mem[word_idx[IDX_W-1:0]][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // read data and error, sampled on the grant edge
    always_ff @(posedge clk) begin
        if (grant) begin
            bus.err   <= !in_range;
            bus.rdata <= in_range ? mem[word_idx[IDX_W-1:0]] : '0;
        end
    end

endmodule

/* tb/lsu_tests.txt */
// op(1 store) size(0 byte 1 half 2 word) unsigned addr wdata exp_rdata exp_err, all hex
// memory is all zero after reset, 256 words
1 2 0 00000010 12345678 00000000 0
0 2 0 00000010 00000000 12345678 0
1 2 0 00000020 11223344 00000000 0
1 0 0 00000021 000000ab 00000000 0
1 1 0 00000022 0000cdef 00000000 0
0 2 0 00000020 00000000 cdefab44 0
0 0 0 00000020 00000000 00000044 0
0 0 0 00000021 00000000 ffffffab 0
0 0 0 00000022 00000000 ffffffef 0
0 0 0 00000023 00000000 ffffffcd 0
0 0 1 00000020 00000000 00000044 0
0 0 1 00000021 00000000 000000ab 0
0 0 1 00000022 00000000 000000ef 0
0 0 1 00000023 00000000 000000cd 0
0 1 0 00000020 00000000 ffffab44 0
0 1 0 00000022 00000000 ffffcdef 0
0 1 1 00000020 00000000 0000ab44 0
0 1 1 00000022 00000000 0000cdef 0
1 1 0 00000021 0000ffff 00000000 1
1 2 0 00000022 ffffffff 00000000 1
0 2 0 00000013 00000000 00000000 1
0 1 0 00000023 00000000 00000000 1
0 2 0 00000020 00000000 cdefab44 0
1 2 0 00000400 deadbeef 00000000 1
0 2 0 00000400 00000000 00000000 1
0 0 0 000007ff 00000000 00000000 1
0 2 0 00000000 00000000 00000000 0
1 2 0 000003fc cafef00d 00000000 0
0 2 0 000003fc 00000000 cafef00d 0

/* tb/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

    localparam int MAX_VECS   = 64;
    localparam int WAIT_LIMIT = 50;

    // one access: op size uns addr wdata exp_rdata exp_err
    logic [31:0] vecs [MAX_VECS][7];
    int          num_vecs;
    int          errors;
    int          cur_vec;
    logic        timed_out;
    logic [31:0] lfsr;

    logic        clk;
    logic        rst_n;
    logic        core_valid;
    logic        core_ready;
    logic [31:0] core_addr;
    logic        core_we;
    lsu_size_e   core_size;
    logic        core_unsigned;
    logic [31:0] core_wdata;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        resp_err;

    // two cycle grant delay keeps the address phase stalled
    lsu_top #(.ADDR_WIDTH(32), .MEM_WORDS(256), .GNT_WAIT(2)) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_valid_i    (core_valid),
        .core_ready_o    (core_ready),
        .core_addr_i     (core_addr),
        .core_we_i       (core_we),
        .core_size_i     (core_size),
        .core_unsigned_i (core_unsigned),
        .core_wdata_i    (core_wdata),
        .resp_valid_o    (resp_valid),
        .resp_rdata_o    (resp_rdata),
        .resp_err_o      (resp_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 32 bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s vector %0d: got %h expected %h", name, cur_vec, got, exp);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        fd = $fopen("tb/lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/lsu_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd) && num_vecs < MAX_VECS) begin
                n = $fgets(line, fd);
                // nothing read at end of file
                if (n > 0) begin
                    // comment and blank lines scan fewer than seven fields
                    if ($sscanf(line, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]) == 7) begin
                        vecs[num_vecs] = f;
                        num_vecs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // polls one cycle at a time, sampling just after the edge
    task automatic wait_core_ready(output logic ok);
        int cycles;
        cycles = 0;
        while (!core_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = core_ready;
    endtask

    // same polling for the response pulse
    task automatic wait_resp_valid(output logic ok);
        int cycles;
        cycles = 0;
        while (!resp_valid && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = resp_valid;
    endtask

    initial begin : run
        logic       ok;
        logic [1:0] gap;
        errors = 0;
        num_vecs = 0;
        timed_out = 1'b0;
        lfsr = 32'd76345;
        rst_n = 1'b0;
        core_valid = 1'b0;
        core_addr = '0;
        core_we = 1'b0;
        core_size = BYTE;
        core_unsigned = 1'b0;
        core_wdata = '0;
        load_vectors();
        if (num_vecs == 0) begin
            $display("no vectors were read");
            errors++;
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("core_ready_o", core_ready, 1);
        check_value("resp_valid_o", resp_valid, 0);
        check_value("resp_err_o", resp_err, 0);
        for (int i = 0; i < num_vecs && !timed_out; i++) begin
            cur_vec = i;
            // 0 to 3 idle cycles, one lfsr step per bit
            lfsr = lfsr_next(lfsr);
            gap[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            gap[1] = lfsr[0];
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            wait_core_ready(ok);
            if (!ok) begin
                $display("timed out waiting for core_ready_o at vector %0d", i);
                errors++;
                timed_out = 1'b1;
            end else begin
                core_valid = 1'b1;
                core_we = vecs[i][0][0];
                core_size = lsu_size_e'(vecs[i][1][1:0]);
                core_unsigned = vecs[i][2][0];
                core_addr = vecs[i][3];
                core_wdata = vecs[i][4];
                // accepted on this edge
                @(posedge clk);
                #1 core_valid = 1'b0;
                wait_resp_valid(ok);
                if (!ok) begin
                    $display("timed out waiting for resp_valid_o at vector %0d", i);
                    errors++;
                    timed_out = 1'b1;
                end else begin
                    check_value("resp_rdata_o", resp_rdata, vecs[i][5]);
                    check_value("resp_err_o", resp_err, vecs[i][6]);
                    // pulse must be gone a cycle later
                    @(posedge clk);
                    #1;
                    check_value("resp_valid_o", resp_valid, 0);
                end
            end
        end
        $display("%0d vectors run, %0d errors", num_vecs, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/lsu_pkg.sv
logic/obi_bus_if.sv
logic/lsu_decode.sv
logic/obi_master.sv
logic/lsu_result.sv
logic/obi_sram.sv
logic/lsu_top.sv
tb/tb_lsu_top.sv
